/* tb.f */
+incdir+bench
verilog/fpu_pkg.sv
verilog/fpu_operand_regs.sv
verilog/fp_addsub.sv
verilog/fp_mul.sv
verilog/fpu_sequencer.sv
verilog/fpu.sv
bench/fpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fpu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

FILE_LIST := tb.f
SOURCES   := $(filter-out +incdir%,$(shell cat $(FILE_LIST)))
HEADERS   := bench/fpu_ref.svh
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/fpu_ref.svh */
// reference model for the FPU testbench, included inside the testbench module
// add/sub truncates on align, mul rounds to nearest with ties to even
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// add or subtract two ieee words by the truncating align and normalize rule
function automatic logic [31:0] ref_addsub(input logic [31:0] a, input logic [31:0] b,
                                          input bit sub);
  int     ea;
  int     eb;
  int     e;
  longint va;
  longint vb;
  longint r;
  bit     neg;
  ea = int'(a[30:23]);
  eb = int'(b[30:23]);
  // hidden bit only for a nonzero exponent
  va = (ea != 0) ? longint'({1'b1, a[22:0]}) : longint'(a[22:0]);
  vb = (eb != 0) ? longint'({1'b1, b[22:0]}) : longint'(b[22:0]);
  if (ea >= eb) begin
    vb = vb >> (ea - eb);
    e  = ea;
  end else begin
    va = va >> (eb - ea);
    e  = eb;
  end
  if (a[31]) va = -va;
  // subtracting is adding the operand with its sign flipped
  if (b[31] ^ sub) vb = -vb;
  r   = va + vb;
  neg = r < 0;
  if (neg) r = -r;
  if (r == 0) return 32'h0;
  if (r >= 64'd16777216) begin
    r = r >> 1;
    e = e + 1;
  end
  while (r < 64'd8388608) begin
    r = r << 1;
    e = e - 1;
  end
  return {neg, 8'(e), 23'(r)};
endfunction

// multiply two ieee words, ties go to the even mantissa
function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
  logic [47:0] p;
  logic [23:0] rest;
  logic [24:0] keep;
  int          e;
  p = 48'({|a[30:23], a[22:0]}) * 48'({|b[30:23], b[22:0]});
  e = int'(a[30:23]) + int'(b[30:23]) - exp_bias;
  if (p[47]) e = e + 1;
  else p = p << 1;
  keep = {1'b0, p[47:24]};
  rest = p[23:0];
  // above half rounds up, exactly half only from an odd lsb
  if (rest > 24'h80_0000 || (rest == 24'h80_0000 && keep[0])) keep = keep + 25'd1;
  if (keep[24]) begin
    keep = keep >> 1;
    e    = e + 1;
  end
  return {a[31] ^ b[31], 8'(e), keep[22:0]};
endfunction

`endif

/* bench/fpu_tb.sv */
// directed testbench for the single-precision FPU
// runs reset, handshake, add, sub, mul and result hold tests against a reference model
`timescale 1ns/1ps

module fpu_tb;
  import fpu_pkg::*;

  `include "fpu_ref.svh"

  localparam logic [31:0] lfsr_seed = 32'h1955_4bdc;
  localparam int timeout_cycles = 20;

  logic              clk;
  logic              arst;
  logic [word_w-1:0] a_operand;
  logic [word_w-1:0] b_operand;
  fpu_op_e           operation;
  logic              start;
  logic [word_w-1:0] ieee_packet_out;
  logic              busy;
  logic              cmd_end;
  logic [31:0]       lfsr_state;
  int                check_count;
  int                error_count;

  fpu u_fpu (
    .clk(clk), .arst(arst), .a_operand(a_operand), .b_operand(b_operand),
    .operation(operation), .start(start), .ieee_packet_out(ieee_packet_out),
    .busy(busy), .cmd_end(cmd_end)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // exponent kept in 100..154 so results stay normal
  task automatic random_float(output logic [31:0] f);
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    take_bits(1, s);
    take_bits(6, e);
    take_bits(23, m);
    f = {s[0], 8'(100 + e % 55), m[22:0]};
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    check_count++;
    assert (got === expected)
      else begin
        $display("FAILED %s: got %h, expected %h", name, got, expected);
        error_count++;
      end
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("%-10s %0d checks, %0d errors", name, check_count - chk0, error_count - err0);
  endtask

  // full command: raise start, wait for cmd_end, check, release, wait for idle
  task automatic do_cmd(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] expected);
    int cycles;
    @(posedge clk);
    a_operand <= a;
    b_operand <= b;
    operation <= op;
    start     <= 1'b1;
    cycles = 0;
    while (cmd_end !== 1'b1 && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    check_count++;
    assert (cmd_end === 1'b1)
      else begin
        $display("timeout: cmd_end never rose for operands %h and %h", a, b);
        error_count++;
      end
    if (cmd_end === 1'b1) check_word("ieee_packet_out", ieee_packet_out, expected);
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    while (busy !== 1'b0 && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    check_count++;
    assert (busy === 1'b0)
      else begin
        $display("timeout: busy stayed high after start was released");
        error_count++;
      end
  endtask

  task automatic run_random(input fpu_op_e op, input int n);
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < n; i++) begin
      random_float(a);
      random_float(b);
      if (op == op_mul) do_cmd(op, a, b, ref_mul(a, b));
      else do_cmd(op, a, b, ref_addsub(a, b, op == op_sub));
    end
  endtask

  task automatic test_reset();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    @(negedge clk);
    check_word("busy", 32'(busy), 32'h0);
    check_word("cmd_end", 32'(cmd_end), 32'h0);
    check_word("ieee_packet_out", ieee_packet_out, 32'h0);
    report_test("reset", chk0, err0);
  endtask

  // cycle counts here are fixed by the command timing
  task automatic test_handshake();
    int          chk0;
    int          err0;
    chk0 = check_count;
    err0 = error_count;
    @(posedge clk);
    a_operand <= 32'h3f80_0000;
    b_operand <= 32'h3f80_0000;
    operation <= op_add;
    start     <= 1'b1;
    // start not sampled yet
    @(negedge clk);
    check_word("busy", 32'(busy), 32'h0);
    // E0 has passed
    @(negedge clk);
    check_word("busy", 32'(busy), 32'h1);
    check_word("cmd_end", 32'(cmd_end), 32'h0);
    @(negedge clk);
    check_word("cmd_end", 32'(cmd_end), 32'h0);
    @(negedge clk);
    check_word("cmd_end", 32'(cmd_end), 32'h1);
    check_word("ieee_packet_out", ieee_packet_out, 32'h4000_0000);
    repeat (10) begin
      @(negedge clk);
      check_word("cmd_end", 32'(cmd_end), 32'h1);
      check_word("busy", 32'(busy), 32'h1);
      check_word("ieee_packet_out", ieee_packet_out, 32'h4000_0000);
    end
    @(posedge clk);
    start <= 1'b0;
    // the edge that drove start low still saw it high
    @(negedge clk);
    check_word("cmd_end", 32'(cmd_end), 32'h1);
    @(negedge clk);
    check_word("busy", 32'(busy), 32'h0);
    check_word("cmd_end", 32'(cmd_end), 32'h0);
    report_test("handshake", chk0, err0);
  endtask

  task automatic test_add();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    do_cmd(op_add, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);
    do_cmd(op_add, 32'h3fc0_0000, 32'hbf00_0000, 32'h3f80_0000);
    do_cmd(op_add, 32'h42f6_e979, 32'hc2f6_e979, 32'h0000_0000);
    run_random(op_add, 40);
    report_test("add", chk0, err0);
  endtask

  task automatic test_sub();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    // exponent differences 0, 1 and 20
    do_cmd(op_sub, 32'h4040_0000, 32'h4000_0000, ref_addsub(32'h4040_0000, 32'h4000_0000, 1));
    do_cmd(op_sub, 32'h4040_0000, 32'h3f80_0000, ref_addsub(32'h4040_0000, 32'h3f80_0000, 1));
    do_cmd(op_sub, 32'h4980_0000, 32'h3fc0_0000, ref_addsub(32'h4980_0000, 32'h3fc0_0000, 1));
    run_random(op_sub, 40);
    report_test("sub", chk0, err0);
  endtask

  task automatic test_mul();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    do_cmd(op_mul, 32'h3fff_ffff, 32'h3fff_ffff, ref_mul(32'h3fff_ffff, 32'h3fff_ffff));
    // mantissas multiply to 2^47 - 1, rounding carries into a new leading bit
    do_cmd(op_mul, 32'h3fa1_e58f, 32'h3fca_6691, ref_mul(32'h3fa1_e58f, 32'h3fca_6691));
    // exact ties, odd lsb rounds up and even lsb stays
    do_cmd(op_mul, 32'h3f80_0001, 32'h3fc0_0000, 32'h3fc0_0002);
    do_cmd(op_mul, 32'h3f80_0003, 32'h3fc0_0000, 32'h3fc0_0004);
    do_cmd(op_mul, 32'hbf80_0003, 32'h3fc0_0000, 32'hbfc0_0004);
    do_cmd(op_mul, 32'hc040_0000, 32'hc000_0000, 32'h40c0_0000);
    run_random(op_mul, 40);
    report_test("mul", chk0, err0);
  endtask

  task automatic test_hold();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    do_cmd(op_mul, 32'h4040_0000, 32'h4000_0000, 32'h40c0_0000);
    repeat (5) @(negedge clk);
    check_word("ieee_packet_out", ieee_packet_out, 32'h40c0_0000);
    // unused code selects a zero result
    do_cmd(fpu_op_e'(2'd3), 32'h4040_0000, 32'h4000_0000, 32'h0000_0000);
    repeat (5) @(negedge clk);
    check_word("ieee_packet_out", ieee_packet_out, 32'h0000_0000);
    report_test("hold", chk0, err0);
  endtask

  initial begin
    arst        = 1'b1;
    start       = 1'b0;
    a_operand   = '0;
    b_operand   = '0;
    operation   = op_add;
    lfsr_state  = lfsr_seed;
    check_count = 0;
    error_count = 0;
    repeat (16) @(posedge clk);
    arst <= 1'b0;
    test_reset();
    test_handshake();
    test_add();
    test_sub();
    test_mul();
    test_hold();
    $display("total %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/fpu.sv */
// single-precision FPU top for add, sub and mul
// host raises start with stable operands, waits for cmd_end, then drops start
`timescale 1ns/1ps

module fpu (
  input  logic                        clk,
  input  logic                        arst,
  input  logic [fpu_pkg::word_w-1:0]  a_operand,
  input  logic [fpu_pkg::word_w-1:0]  b_operand,
  input  fpu_pkg::fpu_op_e            operation,
  input  logic                        start,
  output logic [fpu_pkg::word_w-1:0]  ieee_packet_out,
  output logic                        busy,
  output logic                        cmd_end
);
  import fpu_pkg::*;

  logic              load;
  logic              a_sign;
  logic              b_sign;
  logic [exp_w-1:0]  a_exp;
  logic [exp_w-1:0]  b_exp;
  logic [mant_w-1:0] a_mant;
  logic [mant_w-1:0] b_mant;
  logic              sum_sign;
  logic [exp_w-1:0]  sum_exp;
  logic [mant_w-1:0] sum_mant;
  logic              prod_sign;
  logic [exp_w-1:0]  prod_exp;
  logic [mant_w-1:0] prod_mant;

  fpu_operand_regs u_operand_regs (
    .clk(clk), .arst(arst), .load(load),
    .a_operand(a_operand), .b_operand(b_operand),
    .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
    .a_mant(a_mant), .b_mant(b_mant)
  );

  // both datapaths see the same registered operands
  fp_addsub u_addsub (
    .subtract(operation == op_sub),
    .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
    .a_mant(a_mant), .b_mant(b_mant),
    .sum_sign(sum_sign), .sum_exp(sum_exp), .sum_mant(sum_mant)
  );

  fp_mul u_mul (
    .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
    .a_mant(a_mant), .b_mant(b_mant),
    .prod_sign(prod_sign), .prod_exp(prod_exp), .prod_mant(prod_mant)
  );

  fpu_sequencer u_sequencer (
    .clk(clk), .arst(arst), .start(start), .operation(operation),
    .sum_sign(sum_sign), .sum_exp(sum_exp), .sum_mant(sum_mant),
    .prod_sign(prod_sign), .prod_exp(prod_exp), .prod_mant(prod_mant),
    .load(load), .busy(busy), .cmd_end(cmd_end),
    .ieee_packet_out(ieee_packet_out)
  );

endmodule

/* verilog/fpu_sequencer.sv */
// command sequencer of the FPU
// runs start/busy/cmd_end, pulses the operand load and registers the result
`timescale 1ns/1ps

module fpu_sequencer (
  input  logic                        clk,
  input  logic                        arst,
  input  logic                        start,
  input  fpu_pkg::fpu_op_e            operation,
  input  logic                        sum_sign,
  input  logic [fpu_pkg::exp_w-1:0]   sum_exp,
  input  logic [fpu_pkg::mant_w-1:0]  sum_mant,
  input  logic                        prod_sign,
  input  logic [fpu_pkg::exp_w-1:0]   prod_exp,
  input  logic [fpu_pkg::mant_w-1:0]  prod_mant,
  output logic                        load,
  output logic                        busy,
  output logic                        cmd_end,
  output logic [fpu_pkg::word_w-1:0]  ieee_packet_out
);
  import fpu_pkg::*;

  seq_state_e        state;
  seq_state_e        state_next;
  logic [word_w-1:0] result_sel;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (start) state_next = st_load;
      end
      // operands get captured at the end of this cycle
      st_load: state_next = st_exec;
      // datapaths settle on the captured operands
      st_exec: state_next = st_done;
      st_done: state_next = st_wait_release;
      // host keeps start high as long as it wants the result held
      st_wait_release: begin
        if (!start) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) state <= st_idle;
    else state <= state_next;
  end

  // outputs come from the next state so they switch with the state
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      load    <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      load    <= state_next == st_load;
      busy    <= state_next != st_idle;
      cmd_end <= state_next == st_done || state_next == st_wait_release;
    end
  end

  // pack the chosen datapath, hidden bit dropped
  always_comb begin
    case (operation)
      op_add, op_sub: result_sel = {sum_sign, sum_exp, sum_mant[frac_w-1:0]};
      op_mul:         result_sel = {prod_sign, prod_exp, prod_mant[frac_w-1:0]};
      default:        result_sel = '0;
    endcase
  end

  // written once per command, held until the next one
  always_ff @(posedge clk, posedge arst) begin
    if (arst) ieee_packet_out <= '0;
    else if (state_next == st_done) ieee_packet_out <= result_sel;
  end

  assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("fpu_sequencer: cmd_end without busy");

  // load is the first cycle of a command
  assert property (@(posedge clk) disable iff (arst) load |-> $rose(busy))
    else $error("fpu_sequencer: load outside command start");

endmodule

/* verilog/fp_mul.sv */
// combinational multiply datapath of the FPU
// full mantissa product, normalize, round to nearest even, renormalize
`timescale 1ns/1ps

module fp_mul (
  input  logic                        a_sign,
  input  logic                        b_sign,
  input  logic [fpu_pkg::exp_w-1:0]   a_exp,
  input  logic [fpu_pkg::exp_w-1:0]   b_exp,
  input  logic [fpu_pkg::mant_w-1:0]  a_mant,
  input  logic [fpu_pkg::mant_w-1:0]  b_mant,
  output logic                        prod_sign,
  output logic [fpu_pkg::exp_w-1:0]   prod_exp,
  output logic [fpu_pkg::mant_w-1:0]  prod_mant
);
  import fpu_pkg::*;

  logic [2*mant_w-1:0] product;
  logic [2*mant_w-1:0] product_norm;
  logic [exp_w-1:0]    exp_sum;
  logic [exp_w-1:0]    exp_norm;
  logic [mant_w-1:0]   upper;
  logic                round_bit;
  logic                sticky;
  logic                round_up;
  logic [mant_w:0]     rounded;

  assign prod_sign = a_sign ^ b_sign;
  // both biased exponents carry the bias, drop one of them
  assign exp_sum   = exp_w'(a_exp + b_exp - exp_bias);
  assign product   = a_mant * b_mant;

  // 1.x times 1.x lands in [1,4)
  always_comb begin
    if (product[2*mant_w-1]) begin
      product_norm = product;
      exp_norm     = exp_sum + 1'b1;
    end else begin
      product_norm = product << 1;
      exp_norm     = exp_sum;
    end
  end

  // kept part on top, first dropped bit is the round bit
  assign upper     = product_norm[2*mant_w-1 -: mant_w];
  assign round_bit = product_norm[mant_w-1];
  assign sticky    = |product_norm[mant_w-2:0];
  // exact halfway goes up only from an odd lsb
  assign round_up  = round_bit & (sticky | upper[0]);
  assign rounded   = {1'b0, upper} + (mant_w+1)'(round_up);

  // all ones plus one overflows into a new leading bit
  always_comb begin
    if (rounded[mant_w]) begin
      prod_mant = rounded[mant_w:1];
      prod_exp  = exp_norm + 1'b1;
    end else begin
      prod_mant = rounded[mant_w-1:0];
      prod_exp  = exp_norm;
    end
  end

  // normal inputs must give a normalized mantissa after rounding
  always_comb begin
    assert final (!(a_mant[mant_w-1] && b_mant[mant_w-1]) || prod_mant[mant_w-1])
      else $error("fp_mul: hidden bit lost after renormalization");
  end

endmodule

/* verilog/fp_addsub.sv */
// combinational add/sub datapath of the FPU
// aligns by truncating right shift, adds in two's complement, normalizes by lzc
`timescale 1ns/1ps

module fp_addsub (
  input  logic                        subtract,
  input  logic                        a_sign,
  input  logic                        b_sign,
  input  logic [fpu_pkg::exp_w-1:0]   a_exp,
  input  logic [fpu_pkg::exp_w-1:0]   b_exp,
  input  logic [fpu_pkg::mant_w-1:0]  a_mant,
  input  logic [fpu_pkg::mant_w-1:0]  b_mant,
  output logic                        sum_sign,
  output logic [fpu_pkg::exp_w-1:0]   sum_exp,
  output logic [fpu_pkg::mant_w-1:0]  sum_mant
);
  import fpu_pkg::*;

  // leading zeros of a mantissa, all zero gives mant_w
  function automatic logic [$clog2(mant_w+1)-1:0] lead_zeros(input logic [mant_w-1:0] m);
    logic [$clog2(mant_w+1)-1:0] cnt;
    cnt = ($clog2(mant_w+1))'(mant_w);
    // highest set bit is the last one seen
    for (int i = 0; i < mant_w; i++) begin
      if (m[i]) cnt = ($clog2(mant_w+1))'(mant_w - 1 - i);
    end
    return cnt;
  endfunction

  logic [guard_w-1:0]          a_al;
  logic [guard_w-1:0]          b_al;
  logic [exp_w-1:0]            big_exp;
  logic [guard_w-1:0]          a_signed;
  logic [guard_w-1:0]          b_signed;
  logic [guard_w-1:0]          raw_sum;
  logic [guard_w-1:0]          magnitude;
  logic [$clog2(mant_w+1)-1:0] lz;

  // smaller operand shifts right, bits falling off are lost
  always_comb begin
    a_al = guard_w'(a_mant);
    b_al = guard_w'(b_mant);
    if (a_exp >= b_exp) begin
      b_al    = b_al >> (a_exp - b_exp);
      big_exp = a_exp;
    end else begin
      a_al    = a_al >> (b_exp - a_exp);
      big_exp = b_exp;
    end
  end

  assign a_signed  = a_sign ? -a_al : a_al;
  assign b_signed  = b_sign ? -b_al : b_al;
  assign raw_sum   = subtract ? a_signed - b_signed : a_signed + b_signed;
  // top guard bit carries the result sign
  assign sum_sign  = raw_sum[guard_w-1];
  assign magnitude = sum_sign ? -raw_sum : raw_sum;
  assign lz        = lead_zeros(magnitude[mant_w-1:0]);

  always_comb begin
    if (magnitude == '0) begin
      sum_mant = '0;
      sum_exp  = '0;
    end else if (magnitude[mant_w]) begin
      // carry out of the mantissa
      sum_mant = magnitude[mant_w:1];
      sum_exp  = big_exp + 1'b1;
    end else begin
      sum_mant = magnitude[mant_w-1:0] << lz;
      sum_exp  = big_exp - exp_w'(lz);
    end
  end

endmodule

/* verilog/fpu_operand_regs.sv */
// operand capture stage of the FPU
// splits both ieee words into sign, exponent and mantissa and holds them on load
`timescale 1ns/1ps

module fpu_operand_regs (
  input  logic                        clk,
  input  logic                        arst,
  input  logic                        load,
  input  logic [fpu_pkg::word_w-1:0]  a_operand,
  input  logic [fpu_pkg::word_w-1:0]  b_operand,
  output logic                        a_sign,
  output logic                        b_sign,
  output logic [fpu_pkg::exp_w-1:0]   a_exp,
  output logic [fpu_pkg::exp_w-1:0]   b_exp,
  output logic [fpu_pkg::mant_w-1:0]  a_mant,
  output logic [fpu_pkg::mant_w-1:0]  b_mant
);
  import fpu_pkg::*;

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      a_sign <= 1'b0;
      a_exp  <= '0;
      a_mant <= '0;
      b_sign <= 1'b0;
      b_exp  <= '0;
      b_mant <= '0;
    end else if (load) begin
      a_sign <= a_operand[word_w-1];
      a_exp  <= a_operand[frac_w +: exp_w];
      // hidden bit is one unless the exponent is zero
      a_mant <= {|a_operand[frac_w +: exp_w], a_operand[frac_w-1:0]};
      b_sign <= b_operand[word_w-1];
      b_exp  <= b_operand[frac_w +: exp_w];
      b_mant <= {|b_operand[frac_w +: exp_w], b_operand[frac_w-1:0]};
    end
  end

  // the sequencer pulses load once per command
  assert property (@(posedge clk) disable iff (arst) load |=> !load)
    else $error("fpu_operand_regs: load held for two cycles");

endmodule

/* verilog/fpu_pkg.sv */
// formats, constants and enums shared by the single-precision FPU
// RTL modules import it inside their bodies and the testbench imports it too
package fpu_pkg;

  // ieee-754 single precision word layout
  localparam int word_w = 32;
  localparam int exp_w = 8;
  localparam int frac_w = 23;

  // fraction with the hidden bit in front
  localparam int mant_w = frac_w + 1;

  // add/sub working width with a carry bit and a sign bit above the mantissa
  localparam int guard_w = mant_w + 2;

  localparam int exp_bias = 127;

  // code 2'd3 is unused and gives a zero result
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_e;

  // one command goes idle -> load -> exec -> done -> wait_release
  typedef enum logic [2:0] {
    st_idle         = 3'd0,
    st_load         = 3'd1,
    st_exec         = 3'd2,
    st_done         = 3'd3,
    st_wait_release = 3'd4
  } seq_state_e;

endpackage
